// ==== all.f ====
+incdir+common
common/rename_pkg.sv
rtl/map_table.sv
rtl/free_list.sv
br_stack/br_stack_ent.sv
br_stack/br_stack.sv
rtl/rename_top.sv
test/rename_chk.sv
test/rename_tb.sv

// ==== br_stack/br_stack.sv ====
/*
 * Branch stack
 * One-hot branch mask allocation and resolution, per-slot dispatch masks,
 * and selection of the checkpoint used for wrong-path recovery
 */
`timescale 1ns/100ps
`include "rename_defs.svh"

module br_stack (
	input	logic						clk,
	input	logic						rst,
	input	rename_pkg::br_cmd_t		br_cmd_i,
	input	rename_pkg::cdb_t			cdb_i,
	input	rename_pkg::mt_all_t		mt_next_i,
	input	logic [`FL_PTR_W-1:0]		fl_head_next_i,
	output	logic [`BR_NUM-1:0]			br_tag_o,
	output	logic						full_o,
	output	logic						rc_vld_o,
	output	rename_pkg::mt_all_t		rc_mt_all_o,
	output	logic [`FL_PTR_W-1:0]		rc_fl_head_o
);

	logic [`BR_NUM-1:0]			mask_r;
	// Mask as it was when each slot's branch was dispatched
	logic [`BR_NUM-1:0]			slot_mask_r [`BR_NUM];
	logic [`BR_NUM-1:0]			free_bit;
	logic [`BR_NUM-1:0]			wrong_mask;
	logic						dispatch;
	rename_pkg::mt_all_t		ent_mt [`BR_NUM];
	logic [`FL_PTR_W-1:0]		ent_head [`BR_NUM];

	// Lowest clear bit, zero once every bit is set
	assign free_bit	= ~mask_r & (mask_r + 1'b1);
	assign full_o	= &mask_r;
	assign dispatch	= (br_cmd_i.op == rename_pkg::BR_DISPATCH) && !full_o;
	assign br_tag_o	= dispatch ? free_bit : '0;
	assign rc_vld_o	= (br_cmd_i.op == rename_pkg::BR_WRONG);

	for (genvar g = 0; g < `BR_NUM; g++) begin : g_ent
		br_stack_ent u_ent (
			.clk			(clk),
			.rst			(rst),
			.mask_bit_i		(mask_r[g]),
			.cdb_i			(cdb_i),
			.bak_mt_i		(mt_next_i),
			.bak_fl_head_i	(fl_head_next_i),
			.rc_mt_all_o	(ent_mt[g]),
			.rc_fl_head_o	(ent_head[g])
		);
	end

	// One-hot select of the resolved slot
	always_comb begin
		rc_mt_all_o		= '0;
		rc_fl_head_o	= '0;
		wrong_mask		= '0;
		for (int i = 0; i < `BR_NUM; i++) begin
			if (br_cmd_i.tag[i]) begin
				rc_mt_all_o		= ent_mt[i];
				rc_fl_head_o	= ent_head[i];
				wrong_mask		= slot_mask_r[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mask_r <= '0;
			for (int i = 0; i < `BR_NUM; i++) begin
				slot_mask_r[i] <= '0;
			end
		end else begin
			case (br_cmd_i.op)
				rename_pkg::BR_DISPATCH: begin
					// Dispatch while full is dropped
					if (!full_o) begin
						mask_r <= mask_r | free_bit;
						for (int i = 0; i < `BR_NUM; i++) begin
							if (free_bit[i])
								slot_mask_r[i] <= mask_r;
						end
					end
				end
				rename_pkg::BR_CORRECT: begin
					// Also forget the bit in younger slots so a later restore skips it
					mask_r <= mask_r & ~br_cmd_i.tag;
					for (int i = 0; i < `BR_NUM; i++) begin
						slot_mask_r[i] <= slot_mask_r[i] & ~br_cmd_i.tag;
					end
				end
				rename_pkg::BR_WRONG: begin
					// Older mask frees this branch and all younger ones
					mask_r <= wrong_mask;
				end
				default: begin
					mask_r <= mask_r;
				end
			endcase
		end
	end

endmodule

// ==== br_stack/br_stack_ent.sv ====
/*
 * Branch stack entry
 * Tracks the map table and free list head while its mask bit is clear,
 * then holds a frozen checkpoint that still picks up CDB ready bits
 */
`timescale 1ns/100ps
`include "rename_defs.svh"

module br_stack_ent (
	input	logic						clk,
	input	logic						rst,
	input	logic						mask_bit_i,
	input	rename_pkg::cdb_t			cdb_i,
	input	rename_pkg::mt_all_t		bak_mt_i,
	input	logic [`FL_PTR_W-1:0]		bak_fl_head_i,
	output	rename_pkg::mt_all_t		rc_mt_all_o,
	output	logic [`FL_PTR_W-1:0]		rc_fl_head_o
);

	rename_pkg::mt_all_t		cp_mt_r;
	logic [`FL_PTR_W-1:0]		cp_head_r;

	assign rc_mt_all_o	= cp_mt_r;
	assign rc_fl_head_o	= cp_head_r;

	always_ff @(posedge clk) begin
		if (rst) begin
			cp_mt_r		<= '0;
			cp_head_r	<= '0;
		end else if (mask_bit_i) begin
			// Frozen copy, only ready bits move
			for (int i = 0; i < `MT_NUM; i++) begin
				if (cdb_i.vld && (cp_mt_r[i].preg == cdb_i.tag))
					cp_mt_r[i].rdy <= 1'b1;
			end
		end else begin
			// Free slot follows the next state every cycle
			cp_mt_r		<= bak_mt_i;
			cp_head_r	<= bak_fl_head_i;
		end
	end

endmodule

// ==== common/rename_defs.svh ====
/*
 * Rename stage sizes
 * Dimensions of the map table, physical register file, free list and branch stack
 */
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Architectural registers and their index width
`define MT_NUM		8
`define AREG_W		3

// Physical registers and tag width
`define PRF_NUM		16
`define PRF_IDX_W	4

// Free list slots
`define FL_NUM		8
// Three index bits plus one wrap bit
`define FL_PTR_W	4

// Branch stack depth with one mask bit per entry
`define BR_NUM		4

`endif

// ==== common/rename_pkg.sv ====
/*
 * Rename stage types
 * Branch commands, map table entries, and the request, response,
 * CDB and commit records shared by the rename blocks
 */
`include "rename_defs.svh"

package rename_pkg;

	// Only one branch operation per cycle
	typedef enum logic [1:0] {
		BR_NONE,
		BR_DISPATCH,
		BR_CORRECT,
		BR_WRONG
	} br_op_t;

	typedef struct packed {
		br_op_t					op;
		logic [`BR_NUM-1:0]		tag;	// One-hot branch mask bit
	} br_cmd_t;

	// Ready bit sits on top of the physical tag
	typedef struct packed {
		logic					rdy;
		logic [`PRF_IDX_W-1:0]	preg;
	} mt_entry_t;

	typedef mt_entry_t [`MT_NUM-1:0] mt_all_t;

	typedef struct packed {
		logic					vld;
		logic [`AREG_W-1:0]		dest_areg;
		logic [`AREG_W-1:0]		src1_areg;
		logic [`AREG_W-1:0]		src2_areg;
	} rename_req_t;

	typedef struct packed {
		logic					vld;
		logic [`PRF_IDX_W-1:0]	dest_preg;
		logic [`PRF_IDX_W-1:0]	old_preg;
		mt_entry_t				src1;
		mt_entry_t				src2;
	} rename_rsp_t;

	// Completion broadcast on the common data bus
	typedef struct packed {
		logic					vld;
		logic [`PRF_IDX_W-1:0]	tag;
	} cdb_t;

	// Old mapping released at retirement
	typedef struct packed {
		logic					vld;
		logic [`PRF_IDX_W-1:0]	preg;
	} commit_t;

endpackage

// ==== rtl/free_list.sv ====
/*
 * Free list
 * Circular queue of free physical tags with wrap-bit pointers
 * Branch recovery rewinds the head while the tail keeps every commit
 */
`timescale 1ns/100ps
`include "rename_defs.svh"

module free_list (
	input	logic						clk,
	input	logic						rst,
	input	logic						pop_i,
	input	rename_pkg::commit_t		commit_i,
	input	logic						rc_vld_i,
	input	logic [`FL_PTR_W-1:0]		rc_head_i,
	output	logic [`PRF_IDX_W-1:0]		head_preg_o,
	output	logic						empty_o,
	output	logic [`FL_PTR_W-1:0]		head_next_o
);

	localparam int unsigned PW = `PRF_IDX_W;
	localparam int unsigned IW = `FL_PTR_W - 1;

	logic [PW-1:0]				slot_r [`FL_NUM];
	logic [`FL_PTR_W-1:0]		head_r;
	logic [`FL_PTR_W-1:0]		tail_r;
	logic [`FL_PTR_W-1:0]		head_nxt;

	// Same index and same wrap bit means nothing left
	assign empty_o		= (head_r == tail_r);
	assign head_preg_o	= slot_r[head_r[IW-1:0]];

	always_comb begin
		head_nxt = head_r;
		if (rc_vld_i)
			head_nxt = rc_head_i;
		else if (pop_i)
			head_nxt = head_r + 1'b1;
	end

	// Checkpoints capture the head after this cycle's pop
	assign head_next_o = head_nxt;

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			// Tail one lap ahead, queue starts full
			tail_r <= `FL_PTR_W'(`FL_NUM);
			for (int i = 0; i < `FL_NUM; i++) begin
				slot_r[i] <= PW'(`MT_NUM + i);
			end
		end else begin
			head_r <= head_nxt;
			// Released tag goes behind the remaining free tags
			if (commit_i.vld) begin
				slot_r[tail_r[IW-1:0]]	<= commit_i.preg;
				tail_r					<= tail_r + 1'b1;
			end
		end
	end

endmodule

// ==== rtl/map_table.sv ====
/*
 * Map table
 * Architectural to physical mapping with ready bits, CDB forwarding on lookup,
 * and a next-state view that the branch checkpoints follow
 */
`timescale 1ns/100ps
`include "rename_defs.svh"

module map_table (
	input	logic						clk,
	input	logic						rst,
	input	rename_pkg::rename_req_t	req_i,
	input	logic [`PRF_IDX_W-1:0]		new_preg_i,
	input	logic						alloc_i,
	input	rename_pkg::cdb_t			cdb_i,
	input	logic						rc_vld_i,
	input	rename_pkg::mt_all_t		rc_mt_all_i,
	output	rename_pkg::mt_entry_t		src1_o,
	output	rename_pkg::mt_entry_t		src2_o,
	output	logic [`PRF_IDX_W-1:0]		old_preg_o,
	output	rename_pkg::mt_all_t		mt_next_o
);

	localparam int unsigned PW = `PRF_IDX_W;

	rename_pkg::mt_all_t	mt_r;
	rename_pkg::mt_all_t	mt_nxt;

	// Mark an entry ready when the broadcast tag matches it
	function automatic rename_pkg::mt_entry_t cdb_fwd(
		input rename_pkg::mt_entry_t	ent,
		input rename_pkg::cdb_t			cdb
	);
		rename_pkg::mt_entry_t res;
		res = ent;
		if (cdb.vld && (cdb.tag == ent.preg))
			res.rdy = 1'b1;
		return res;
	endfunction

	// Sources read the current table, before this cycle's destination write
	assign src1_o		= cdb_fwd(mt_r[req_i.src1_areg], cdb_i);
	assign src2_o		= cdb_fwd(mt_r[req_i.src2_areg], cdb_i);
	assign old_preg_o	= mt_r[req_i.dest_areg].preg;

	always_comb begin
		// Recovery replaces the whole table
		mt_nxt = rc_vld_i ? rc_mt_all_i : mt_r;
		// Broadcast applies on top of a restored copy as well
		for (int i = 0; i < `MT_NUM; i++) begin
			mt_nxt[i] = cdb_fwd(mt_nxt[i], cdb_i);
		end
		// New destination is pending until its CDB broadcast
		if (alloc_i) begin
			mt_nxt[req_i.dest_areg].rdy		= 1'b0;
			mt_nxt[req_i.dest_areg].preg	= new_preg_i;
		end
	end

	assign mt_next_o = mt_nxt;

	always_ff @(posedge clk) begin
		if (rst) begin
			// Identity mapping, all ready
			for (int i = 0; i < `MT_NUM; i++) begin
				mt_r[i].rdy		<= 1'b1;
				mt_r[i].preg	<= PW'(i);
			end
		end else begin
			mt_r <= mt_nxt;
		end
	end

endmodule

// ==== rtl/rename_top.sv ====
/*
 * Rename stage top level
 * Map table, free list and branch stack with allocation gated by stall
 */
`timescale 1ns/100ps
`include "rename_defs.svh"

module rename_top (
	input	logic						clk,
	input	logic						rst,
	input	rename_pkg::rename_req_t	req_i,
	input	rename_pkg::br_cmd_t		br_cmd_i,
	input	rename_pkg::cdb_t			cdb_i,
	input	rename_pkg::commit_t		commit_i,
	output	rename_pkg::rename_rsp_t	rsp_o,
	output	logic [`BR_NUM-1:0]			br_tag_o,
	output	logic						stall_o,
	output	logic						br_full_o
);

	logic						alloc;
	logic						fl_empty;
	logic [`PRF_IDX_W-1:0]		new_preg;
	logic [`PRF_IDX_W-1:0]		old_preg;
	rename_pkg::mt_entry_t		src1;
	rename_pkg::mt_entry_t		src2;
	rename_pkg::mt_all_t		mt_next;
	logic [`FL_PTR_W-1:0]		fl_head_next;
	logic						rc_vld;
	rename_pkg::mt_all_t		rc_mt_all;
	logic [`FL_PTR_W-1:0]		rc_fl_head;

	// Rename goes ahead only with a free tag at the head
	assign alloc	= req_i.vld && !fl_empty;
	assign stall_o	= fl_empty;

	// Response in the request cycle
	assign rsp_o.vld		= alloc;
	assign rsp_o.dest_preg	= new_preg;
	assign rsp_o.old_preg	= old_preg;
	assign rsp_o.src1		= src1;
	assign rsp_o.src2		= src2;

	map_table u_map_table (
		.clk			(clk),
		.rst			(rst),
		.req_i			(req_i),
		.new_preg_i		(new_preg),
		.alloc_i		(alloc),
		.cdb_i			(cdb_i),
		.rc_vld_i		(rc_vld),
		.rc_mt_all_i	(rc_mt_all),
		.src1_o			(src1),
		.src2_o			(src2),
		.old_preg_o		(old_preg),
		.mt_next_o		(mt_next)
	);

	free_list u_free_list (
		.clk			(clk),
		.rst			(rst),
		.pop_i			(alloc),
		.commit_i		(commit_i),
		.rc_vld_i		(rc_vld),
		.rc_head_i		(rc_fl_head),
		.head_preg_o	(new_preg),
		.empty_o		(fl_empty),
		.head_next_o	(fl_head_next)
	);

	br_stack u_br_stack (
		.clk			(clk),
		.rst			(rst),
		.br_cmd_i		(br_cmd_i),
		.cdb_i			(cdb_i),
		.mt_next_i		(mt_next),
		.fl_head_next_i	(fl_head_next),
		.br_tag_o		(br_tag_o),
		.full_o			(br_full_o),
		.rc_vld_o		(rc_vld),
		.rc_mt_all_o	(rc_mt_all),
		.rc_fl_head_o	(rc_fl_head)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the rename stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f all.f --top-module rename_tb \
	--Mdir obj_dir -o rename_sim

# Run from the project root so the data file path resolves
./obj_dir/rename_sim

// ==== test/rename_chk.sv ====
/*
 * Rename stage checker
 * Concurrent assertions on branch mask fullness, free list stall and dispatch tags
 */
`timescale 1ns/100ps
`include "rename_defs.svh"

module rename_chk (
	input	logic						clk,
	input	logic						rst,
	input	rename_pkg::br_cmd_t		br_cmd_i,
	input	logic [`BR_NUM-1:0]			br_tag_i,
	input	logic [`BR_NUM-1:0]			mask_i,
	input	logic						stall_i,
	input	logic						commit_vld_i,
	input	logic						br_full_i
);

	// Dispatch that takes the last clear mask bit fills the stack
	full_on_last_bit: assert property (@(posedge clk) disable iff (rst)
		(br_tag_i != '0 && ((mask_i | br_tag_i) == '1)) |=> br_full_i)
		else $error("br_full_o low after the last mask bit was taken");

	// Any resolution frees at least its own mask bit
	full_drops_on_resolve: assert property (@(posedge clk) disable iff (rst)
		(br_full_i && (br_cmd_i.op == rename_pkg::BR_CORRECT ||
			br_cmd_i.op == rename_pkg::BR_WRONG)) |=> !br_full_i)
		else $error("br_full_o still high after a branch resolution");

	// Empty free list refills only through a commit or a head rewind
	stall_holds: assert property (@(posedge clk) disable iff (rst)
		(stall_i && !commit_vld_i && br_cmd_i.op != rename_pkg::BR_WRONG) |=> stall_i)
		else $error("stall_o dropped with no commit or recovery");

	// Accepted dispatch hands out exactly one mask bit
	onehot_dispatch_tag: assert property (@(posedge clk) disable iff (rst)
		(br_cmd_i.op == rename_pkg::BR_DISPATCH && !br_full_i) |-> $onehot(br_tag_i))
		else $error("br_tag_o is not one-hot on a dispatch");

endmodule

bind rename_top rename_chk chk0 (
	.clk			(clk),
	.rst			(rst),
	.br_cmd_i		(br_cmd_i),
	.br_tag_i		(br_tag_o),
	.mask_i			(u_br_stack.mask_r),
	.stall_i		(stall_o),
	.commit_vld_i	(commit_i.vld),
	.br_full_i		(br_full_o)
);

// ==== test/rename_input.txt ====
// In:  req_vld dest src1 src2 br_op br_tag cdb_vld cdb_tag cmt_vld cmt_preg
// Exp: rsp_vld dest_preg old_preg src1 src2 br_tag stall br_full (src = rdy*10h + preg)
// Reset mapping and allocation
1 1 2 3 0 0 0 00 0 00   1 08 01 12 13 0 0 0
1 2 1 4 0 0 0 00 0 00   1 09 02 08 14 0 0 0
1 3 1 2 0 0 0 00 0 00   1 0a 03 08 09 0 0 0
// CDB readiness, then same-cycle forwarding
0 0 0 0 0 0 1 08 0 00   0 00 00 00 00 0 0 0
1 4 1 3 0 0 1 0a 0 00   1 0b 04 18 1a 0 0 0
1 5 3 2 0 0 0 00 0 00   1 0c 05 1a 09 0 0 0
// Wrong-branch recovery
1 6 0 7 0 0 0 00 0 00   1 0d 06 10 17 0 0 0
0 0 0 0 1 0 0 00 0 00   0 00 00 00 00 1 0 0
1 2 6 4 0 0 0 00 0 00   1 0e 09 0d 0b 0 0 0
1 6 2 1 0 0 1 0b 0 00   1 0f 0d 0e 18 0 0 0
0 0 0 0 3 1 0 00 0 00   0 00 00 00 00 0 1 0
1 7 2 4 0 0 0 00 0 00   1 0e 07 09 1b 0 0 0
// Branch mask, commits refill the free list meanwhile
0 0 0 0 1 0 0 00 1 01   0 00 00 00 00 1 0 0
0 0 0 0 1 0 0 00 1 02   0 00 00 00 00 2 0 0
0 0 0 0 1 0 0 00 1 03   0 00 00 00 00 4 0 0
0 0 0 0 1 0 0 00 1 04   0 00 00 00 00 8 0 0
0 0 0 0 1 0 0 00 1 05   0 00 00 00 00 0 0 1
0 0 0 0 2 2 0 00 1 06   0 00 00 00 00 0 0 1
0 0 0 0 1 0 0 00 1 07   0 00 00 00 00 2 0 0
0 0 0 0 3 4 0 00 0 00   0 00 00 00 00 0 0 1
0 0 0 0 1 0 0 00 0 00   0 00 00 00 00 2 0 0
0 0 0 0 1 0 0 00 0 00   0 00 00 00 00 4 0 0
0 0 0 0 3 1 0 00 0 00   0 00 00 00 00 0 0 0
// Free list limits, eight renames empty it
1 0 0 7 0 0 0 00 0 00   1 0f 00 10 0e 0 0 0
1 0 0 7 0 0 0 00 0 00   1 01 0f 0f 0e 0 0 0
1 0 0 7 0 0 0 00 0 00   1 02 01 01 0e 0 0 0
1 0 0 7 0 0 0 00 0 00   1 03 02 02 0e 0 0 0
1 0 0 7 0 0 0 00 0 00   1 04 03 03 0e 0 0 0
1 0 0 7 0 0 0 00 0 00   1 05 04 04 0e 0 0 0
1 0 0 7 0 0 0 00 0 00   1 06 05 05 0e 0 0 0
1 0 0 7 0 0 0 00 0 00   1 07 06 06 0e 0 0 0
1 0 0 7 0 0 0 00 1 00   0 00 00 00 00 0 1 0
1 1 0 1 0 0 0 00 1 0f   1 00 08 07 18 0 0 0
1 2 1 3 0 0 0 00 0 00   1 0f 09 00 1a 0 0 0
0 0 0 0 0 0 0 00 0 00   0 00 00 00 00 0 1 0

// ==== test/rename_tb.sv ====
/*
 * Rename stage testbench
 * Applies one vector per cycle from the data file and checks the
 * combinational response, branch tag and back-pressure flags
 */
`timescale 1ns/100ps
`include "rename_defs.svh"

module rename_tb;

	// Fields per vector line and room for vectors
	localparam int NF		= 18;
	localparam int MAX_VEC	= 64;

	logic						clk = 1'b0;
	logic						rst;
	rename_pkg::rename_req_t	req;
	rename_pkg::br_cmd_t		br_cmd;
	rename_pkg::cdb_t			cdb;
	rename_pkg::commit_t		commit;
	rename_pkg::rename_rsp_t	rsp;
	logic [`BR_NUM-1:0]			br_tag;
	logic						stall;
	logic						br_full;

	logic [7:0]					vec_mem [MAX_VEC*NF];
	int							num_vec;
	int							cycle_cnt = 0;
	int							cycle_limit = 1000;

	rename_top dut0 (
		.clk		(clk),
		.rst		(rst),
		.req_i		(req),
		.br_cmd_i	(br_cmd),
		.cdb_i		(cdb),
		.commit_i	(commit),
		.rsp_o		(rsp),
		.br_tag_o	(br_tag),
		.stall_o	(stall),
		.br_full_o	(br_full)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// Hung run guard, limit set once the vectors are counted
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("Timeout: no verdict after %0d cycles", cycle_cnt);
			$display("Testbench failed");
			$fatal(1, "Simulation timed out");
		end
	end

	task automatic check_val(input int idx, input string what,
			input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: vector %0d %s is %h, expected %h",
				$time, idx, what, got, exp);
			$display("Testbench failed");
			$fatal(1, "Output mismatch");
		end
	endtask

	initial begin
		int base;

		// Quiet inputs, reset held
		rst		= 1'b1;
		req		= '0;
		br_cmd	= '0;
		cdb		= '0;
		commit	= '0;

		// Unused words keep a sentinel that ends the vector count
		for (int i = 0; i < MAX_VEC*NF; i++) begin
			vec_mem[i] = 8'hff;
		end
		$readmemh("test/rename_input.txt", vec_mem);
		num_vec = 0;
		while (num_vec < MAX_VEC && vec_mem[num_vec*NF] != 8'hff) begin
			num_vec++;
		end
		if (num_vec == 0) begin
			$display("No vectors could be read from test/rename_input.txt");
			$display("Testbench failed");
			$fatal(1, "Missing stimulus");
		end
		cycle_limit = num_vec + 20;

		repeat (2) @(posedge clk);
		rst <= 1'b0;

		for (int v = 0; v < num_vec; v++) begin
			base = v * NF;
			@(posedge clk);
			req.vld			<= vec_mem[base][0];
			req.dest_areg	<= vec_mem[base+1][`AREG_W-1:0];
			req.src1_areg	<= vec_mem[base+2][`AREG_W-1:0];
			req.src2_areg	<= vec_mem[base+3][`AREG_W-1:0];
			br_cmd.op		<= rename_pkg::br_op_t'(vec_mem[base+4][1:0]);
			br_cmd.tag		<= vec_mem[base+5][`BR_NUM-1:0];
			cdb.vld			<= vec_mem[base+6][0];
			cdb.tag			<= vec_mem[base+7][`PRF_IDX_W-1:0];
			commit.vld		<= vec_mem[base+8][0];
			commit.preg		<= vec_mem[base+9][`PRF_IDX_W-1:0];

			// Outputs settle well before the falling edge
			@(negedge clk);
			check_val(v, "rsp.vld", 8'(rsp.vld), vec_mem[base+10]);
			// Payload only matters for an accepted rename
			if (vec_mem[base+10][0]) begin
				check_val(v, "rsp.dest_preg", 8'(rsp.dest_preg), vec_mem[base+11]);
				check_val(v, "rsp.old_preg", 8'(rsp.old_preg), vec_mem[base+12]);
				check_val(v, "rsp.src1", 8'(rsp.src1), vec_mem[base+13]);
				check_val(v, "rsp.src2", 8'(rsp.src2), vec_mem[base+14]);
			end
			check_val(v, "br_tag_o", 8'(br_tag), vec_mem[base+15]);
			check_val(v, "stall_o", 8'(stall), vec_mem[base+16]);
			check_val(v, "br_full_o", 8'(br_full), vec_mem[base+17]);
		end

		// Back to idle before the verdict
		@(posedge clk);
		req		<= '0;
		br_cmd	<= '0;
		cdb		<= '0;
		commit	<= '0;
		@(posedge clk);
		$display("Testbench passed");
		$finish;
	end

endmodule
